/* source/issue_consts.svh */
/*
 * Issue stage sizing macros: bundle width, queue count and depth,
 * operand, ROB tag and free-slot count widths
 */

`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// ========================================
// Bundle and queue sizing
// ========================================
// Packets per issue bundle
`define ISSUE_WIDTH 2

// ALU0..2, MUL0, LOAD0, BRANCH0
`define FU_NUM 6

// Entries in each per-unit queue
`define FU_FIFO_DEPTH 4

// ========================================
// Payload widths
// ========================================
// Operand width
`define XLEN 64

// Reorder-buffer tag
`define ROB_TAG_BITS 6

// Saturated free-slot count, holds 0..ISSUE_WIDTH and depth+1 values
`define FU_CNT_BITS 3

`endif

/* source/isa_pkg.sv */
/*
 * ISA level types: opcode and functional-unit class enums,
 * opcode to class decode function
 */

package isa_pkg;

    // ========================================
    // Opcodes
    // ========================================
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        MUL = 4'd6,
        LD  = 4'd7,
        BEQ = 4'd8,
        BNE = 4'd9
    } opcode_e;

    // ========================================
    // Functional-unit classes
    // ========================================
    // Prefixed so the names stay apart from the opcodes
    typedef enum logic [1:0] {
        CLASS_ALU    = 2'd0,
        CLASS_MUL    = 2'd1,
        CLASS_LOAD   = 2'd2,
        CLASS_BRANCH = 2'd3
    } fu_class_e;

    // Opcode to unit class, unknown encodings fall back to ALU
    function automatic fu_class_e opcode_class(opcode_e op);
        fu_class_e cls;
        case (op)
            MUL:      cls = CLASS_MUL;
            LD:       cls = CLASS_LOAD;
            BEQ, BNE: cls = CLASS_BRANCH;
            default:  cls = CLASS_ALU;
        endcase
        return cls;
    endfunction

endpackage

/* source/issue_pkg.sv */
/*
 * Issue stage types: per-unit queue index enum and issue packet struct
 */

`include "issue_consts.svh"

package issue_pkg;

    import isa_pkg::*;

    // ========================================
    // Queue indices
    // ========================================
    // Also the bit position of each unit in the per-unit vectors
    typedef enum logic [2:0] {
        ALU0    = 3'd0,
        ALU1    = 3'd1,
        ALU2    = 3'd2,
        MUL0    = 3'd3,
        LOAD0   = 3'd4,
        BRANCH0 = 3'd5
    } fu_index_e;

    // ========================================
    // Issue packet
    // ========================================
    // One operation with its operands already read
    typedef struct packed {
        opcode_e                   opcode;
        // Tag back to the reorder buffer
        logic [`ROB_TAG_BITS-1:0]  rob_tag;
        // Source operand values
        logic [`XLEN-1:0]          src1;
        logic [`XLEN-1:0]          src2;
    } issue_packet_t;

endpackage

/* source/fu_fifo.sv */
/*
 * Per-unit circular packet FIFO, zero-latency read,
 * full and empty flags, free-slot count saturated to the issue width
 */

`timescale 1ns/1ps

`include "issue_consts.svh"

module fu_fifo import issue_pkg::*; #(
    parameter int unsigned FIFO_DEPTH  = `FU_FIFO_DEPTH,
    parameter int unsigned ISSUE_WIDTH = `ISSUE_WIDTH
)(
    input  logic                    clk,
    input  logic                    reset,

    // Dispatch side
    input  logic                    wr_en_i,
    input  issue_packet_t           pkt_i,
    output logic [`FU_CNT_BITS-1:0] free_slots_o,
    output logic                    full_o,

    // Functional-unit side
    input  logic                    rd_en_i,
    output issue_packet_t           pkt_o,
    output logic                    empty_o
);

    localparam int unsigned PTR_BITS  = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_BITS  = $clog2(FIFO_DEPTH + 1);
    localparam int unsigned SLOT_BITS = `FU_CNT_BITS;

    // ========================================
    // State
    // ========================================
    issue_packet_t           mem [FIFO_DEPTH];

    // Head is next read, tail is next write
    logic [PTR_BITS-1:0]     head_q, head_d;
    logic [PTR_BITS-1:0]     tail_q, tail_d;

    // Occupancy
    logic [CNT_BITS-1:0]     count_q, count_d;
    logic [CNT_BITS-1:0]     real_spots;

    logic                    wr_valid;
    logic                    rd_valid;

    // ========================================
    // Flags and qualified strobes
    // ========================================
    assign empty_o  = (count_q == '0);
    assign full_o   = (count_q == CNT_BITS'(FIFO_DEPTH));

    // Read only what is there
    assign rd_valid = rd_en_i && !empty_o;
    // Full queue takes a write only alongside a pop
    assign wr_valid = wr_en_i && (!full_o || rd_valid);

    // Space left, capped at what one bundle can use
    assign real_spots   = CNT_BITS'(FIFO_DEPTH) - count_q;
    assign free_slots_o = (real_spots >= CNT_BITS'(ISSUE_WIDTH)) ?
                          SLOT_BITS'(ISSUE_WIDTH) : SLOT_BITS'(real_spots);

    // ========================================
    // Pointer and count update
    // ========================================
    always_comb begin
        head_d  = head_q;
        tail_d  = tail_q;
        count_d = count_q;
        if (wr_valid) begin
            tail_d = (tail_q == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : tail_q + 1'b1;
        end
        if (rd_valid) begin
            head_d = (head_q == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : head_q + 1'b1;
        end
        // Push and pop together leave occupancy unchanged
        case ({wr_valid, rd_valid})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_d;
            tail_q  <= tail_d;
            count_q <= count_d;
        end
    end

    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[tail_q] <= pkt_i;
        end
    end

    // Head packet visible in the read cycle, zero otherwise
    assign pkt_o = rd_valid ? mem[head_q] : '0;

endmodule

/* source/fu_fifo_bank.sv */
/*
 * Bank of per-unit packet FIFOs: ALU0..2, MUL0, LOAD0, BRANCH0
 */

`timescale 1ns/1ps

`include "issue_consts.svh"

module fu_fifo_bank import issue_pkg::*; (
    input  logic                                      clk,
    input  logic                                      reset,

    // ========================================
    // Dispatch to queues
    // ========================================
    input  logic          [`FU_NUM-1:0]               fu_wr_en_i,
    input  issue_packet_t [`FU_NUM-1:0]               fu_wr_pkt_i,
    output logic          [`FU_NUM-1:0]               fu_full_o,
    output logic          [`FU_NUM-1:0][`FU_CNT_BITS-1:0] fu_free_slots_o,

    // ========================================
    // Queues to functional units
    // ========================================
    // One read strobe per unit
    input  logic          [`FU_NUM-1:0]               fu_rd_en_i,
    // Head packet under a valid read
    output issue_packet_t [`FU_NUM-1:0]               fu_pkt_o,
    output logic          [`FU_NUM-1:0]               fu_empty_o
);

    // ========================================
    // One queue per unit
    // ========================================
    // Separate queues so a stalled unit only backs up its own traffic
    for (genvar u = 0; u < `FU_NUM; u++) begin : g_fu
        // Unit served by this queue
        localparam fu_index_e UNIT = fu_index_e'(u);

        fu_fifo #(
            .FIFO_DEPTH  (`FU_FIFO_DEPTH),
            .ISSUE_WIDTH (`ISSUE_WIDTH)
        ) i_fu_fifo (
            .clk          (clk),
            .reset        (reset),
            .wr_en_i      (fu_wr_en_i[UNIT]),
            .pkt_i        (fu_wr_pkt_i[UNIT]),
            .free_slots_o (fu_free_slots_o[UNIT]),
            .full_o       (fu_full_o[UNIT]),
            .rd_en_i      (fu_rd_en_i[UNIT]),
            .pkt_o        (fu_pkt_o[UNIT]),
            .empty_o      (fu_empty_o[UNIT])
        );
    end

endmodule

/* source/issue_dispatch.sv */
/*
 * Bundle dispatch: opcode class decode, ALU spreading, same-queue
 * collision handling, per-unit write strobes, stall and done mask
 */

`timescale 1ns/1ps

`include "issue_consts.svh"

module issue_dispatch import isa_pkg::*, issue_pkg::*; (
    input  logic                                      clk,
    input  logic                                      reset,

    // Issue bundle
    input  logic          [`ISSUE_WIDTH-1:0]          issue_valid_i,
    input  issue_packet_t [`ISSUE_WIDTH-1:0]          issue_pkt_i,

    // Saturated space per queue
    input  logic          [`FU_NUM-1:0][`FU_CNT_BITS-1:0] fu_free_slots_i,

    // Writes into the bank
    output logic          [`FU_NUM-1:0]               fu_wr_en_o,
    output issue_packet_t [`FU_NUM-1:0]               fu_wr_pkt_o,

    // Hold the bundle upstream
    output logic                                      stall_o
);

    // ========================================
    // Slot decode
    // ========================================
    fu_class_e                     slot_class [`ISSUE_WIDTH];
    // Queues each slot may go to
    logic [`FU_NUM-1:0]            slot_cand  [`ISSUE_WIDTH];

    // Valid and not yet written during this held bundle
    logic [`ISSUE_WIDTH-1:0]       pending;
    logic [`ISSUE_WIDTH-1:0]       accepted;
    logic [`ISSUE_WIDTH-1:0]       done_q, done_d;

    // Queue has at least one free entry
    logic [`FU_NUM-1:0]            free_ok;

    always_comb begin
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            slot_class[s] = opcode_class(issue_pkt_i[s].opcode);
            slot_cand[s]  = '0;
            case (slot_class[s])
                CLASS_ALU: begin
                    slot_cand[s][ALU0] = 1'b1;
                    slot_cand[s][ALU1] = 1'b1;
                    slot_cand[s][ALU2] = 1'b1;
                end
                CLASS_MUL:    slot_cand[s][MUL0]    = 1'b1;
                CLASS_LOAD:   slot_cand[s][LOAD0]   = 1'b1;
                default:      slot_cand[s][BRANCH0] = 1'b1;
            endcase
        end
    end

    assign pending = issue_valid_i & ~done_q;

    for (genvar q = 0; q < `FU_NUM; q++) begin : g_free
        assign free_ok[q] = (fu_free_slots_i[q] != '0);
    end

    // ========================================
    // Allocation in slot order
    // ========================================
    // At most one write per queue per cycle, so a queue already granted
    // is simply skipped and its count never needs the subtraction
    always_comb begin
        fu_wr_en_o  = '0;
        fu_wr_pkt_o = '0;
        accepted    = '0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            for (int q = 0; q < `FU_NUM; q++) begin
                // Lowest index first gives ALU0, ALU1, ALU2 order
                if (pending[s] && !accepted[s] && slot_cand[s][q] &&
                    free_ok[q] && !fu_wr_en_o[q]) begin
                    fu_wr_en_o[q]  = 1'b1;
                    fu_wr_pkt_o[q] = issue_pkt_i[s];
                    accepted[s]    = 1'b1;
                end
            end
        end
    end

    // Any slot left behind holds the whole bundle
    assign stall_o = |(pending & ~accepted);

    // ========================================
    // Done mask
    // ========================================
    // Remember written slots while held, clear once the bundle is taken
    assign done_d = stall_o ? (done_q | accepted) : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_q <= '0;
        end else begin
            done_q <= done_d;
        end
    end

endmodule

/* source/issue_stage_top.sv */
/*
 * Issue stage top: dispatch feeding the per-unit FIFO bank
 */

`timescale 1ns/1ps

`include "issue_consts.svh"

module issue_stage_top import issue_pkg::*; (
    input  logic                                      clk,
    input  logic                                      reset,

    // ========================================
    // Issue bundle in
    // ========================================
    input  logic          [`ISSUE_WIDTH-1:0]          issue_valid_i,
    input  issue_packet_t [`ISSUE_WIDTH-1:0]          issue_pkt_i,
    output logic                                      stall_o,

    // ========================================
    // Functional units
    // ========================================
    input  logic          [`FU_NUM-1:0]               fu_rd_en_i,
    output issue_packet_t [`FU_NUM-1:0]               fu_pkt_o,
    output logic          [`FU_NUM-1:0]               fu_empty_o
);

    // Dispatch to bank
    logic          [`FU_NUM-1:0]                   fu_wr_en;
    issue_packet_t [`FU_NUM-1:0]                   fu_wr_pkt;
    // Bank back to dispatch
    logic          [`FU_NUM-1:0][`FU_CNT_BITS-1:0] fu_free_slots;

    issue_dispatch i_issue_dispatch (
        .clk             (clk),
        .reset           (reset),
        .issue_valid_i   (issue_valid_i),
        .issue_pkt_i     (issue_pkt_i),
        .fu_free_slots_i (fu_free_slots),
        .fu_wr_en_o      (fu_wr_en),
        .fu_wr_pkt_o     (fu_wr_pkt),
        .stall_o         (stall_o)
    );

    // Full flags not needed here, free-slot count covers them
    fu_fifo_bank i_fu_fifo_bank (
        .clk             (clk),
        .reset           (reset),
        .fu_wr_en_i      (fu_wr_en),
        .fu_wr_pkt_i     (fu_wr_pkt),
        .fu_full_o       (),
        .fu_free_slots_o (fu_free_slots),
        .fu_rd_en_i      (fu_rd_en_i),
        .fu_pkt_o        (fu_pkt_o),
        .fu_empty_o      (fu_empty_o)
    );

endmodule

/* sim/issue_stage_checker.sv */
/*
 * Issue stage checker: dispatch and queue model,
 * per-cycle compare of stall, empty flags and read packets
 */

`timescale 1ns/1ps

`include "issue_consts.svh"

module issue_stage_checker import isa_pkg::*, issue_pkg::*; #(
    // Sample point, one ns before the next rising edge
    parameter int SAMPLE_DELAY = 7
)(
    input  logic                             clk,
    input  logic                             reset,
    input  logic          [`ISSUE_WIDTH-1:0] issue_valid_i,
    input  issue_packet_t [`ISSUE_WIDTH-1:0] issue_pkt_i,
    input  logic                             stall_i,
    input  logic          [`FU_NUM-1:0]      fu_rd_en_i,
    input  issue_packet_t [`FU_NUM-1:0]      fu_pkt_i,
    input  logic          [`FU_NUM-1:0]      fu_empty_i,
    output int                               error_count_o,
    output logic                             model_empty_o
);

    localparam int PKT_BITS = $bits(issue_packet_t);

    // Per slot: bit 3 accepted, bits 2:0 target queue
    typedef logic [`ISSUE_WIDTH-1:0][3:0] grant_t;

    issue_packet_t           model_q [`FU_NUM][$];
    logic [`ISSUE_WIDTH-1:0] model_done;
    logic [`ISSUE_WIDTH-1:0] model_acc;
    logic [`FU_NUM-1:0][2:0] occ;
    grant_t                  grant;
    logic                    exp_stall;

    // ========================================
    // Reference dispatch
    // ========================================
    function automatic grant_t predict_grants(
        input logic [`ISSUE_WIDTH-1:0]          valid,
        input issue_packet_t [`ISSUE_WIDTH-1:0] pkts,
        input logic [`ISSUE_WIDTH-1:0]          done,
        input logic [`FU_NUM-1:0][2:0]          used
    );
        grant_t             g;
        logic [`FU_NUM-1:0] taken;
        logic [`FU_NUM-1:0] cand;
        int                 space;
        g     = '0;
        taken = '0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            // Queues of the class: ALU0..2, MUL0, LOAD0 or BRANCH0
            case (opcode_class(pkts[s].opcode))
                CLASS_ALU:  cand = 6'b000111;
                CLASS_MUL:  cand = 6'b001000;
                CLASS_LOAD: cand = 6'b010000;
                default:    cand = 6'b100000;
            endcase
            for (int q = 0; q < `FU_NUM; q++) begin
                // Saturated free count less writes granted this cycle
                space = `FU_FIFO_DEPTH - int'(used[q]);
                if (space > `ISSUE_WIDTH) space = `ISSUE_WIDTH;
                if (taken[q]) space = space - 1;
                // Lowest qualifying queue wins
                if (valid[s] && !done[s] && !g[s][3] && cand[q] &&
                    !taken[q] && space > 0) begin
                    g[s]     = {1'b1, 3'(q)};
                    taken[q] = 1'b1;
                end
            end
        end
        return g;
    endfunction

    task automatic check_value(input string what, input logic [PKT_BITS-1:0] got,
                               input logic [PKT_BITS-1:0] exp);
        if (got !== exp) begin
            error_count_o++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ========================================
    // Per-cycle compare and model update
    // ========================================
    initial begin
        model_done    = '0;
        error_count_o = 0;
        model_empty_o = 1'b1;
        forever begin
            @(posedge clk);
            #(SAMPLE_DELAY);
            if (reset) begin
                for (int u = 0; u < `FU_NUM; u++) model_q[u].delete();
                model_done = '0;
            end
            for (int u = 0; u < `FU_NUM; u++) occ[u] = 3'(model_q[u].size());
            grant     = predict_grants(issue_valid_i, issue_pkt_i, model_done, occ);
            exp_stall = 1'b0;
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                model_acc[s] = grant[s][3];
                // Valid slot left unplaced holds the bundle
                if (issue_valid_i[s] && !model_done[s] && !grant[s][3]) exp_stall = 1'b1;
            end
            check_value("stall_o", PKT_BITS'(stall_i), PKT_BITS'(exp_stall));
            for (int u = 0; u < `FU_NUM; u++) begin
                check_value($sformatf("fu_empty_o[%0d]", u), PKT_BITS'(fu_empty_i[u]),
                            PKT_BITS'(model_q[u].size() == 0));
                if (fu_rd_en_i[u] && model_q[u].size() != 0) begin
                    check_value($sformatf("fu_pkt_o[%0d]", u), fu_pkt_i[u], model_q[u][0]);
                    if (!reset) void'(model_q[u].pop_front());
                end else begin
                    // Idle output reads as zero
                    check_value($sformatf("idle fu_pkt_o[%0d]", u), fu_pkt_i[u], '0);
                end
            end
            // Pushes land at the edge, readable from the next cycle
            if (!reset) begin
                for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                    if (grant[s][3]) model_q[grant[s][2:0]].push_back(issue_pkt_i[s]);
                end
                model_done = exp_stall ? (model_done | model_acc) : '0;
            end
            model_empty_o = 1'b1;
            for (int u = 0; u < `FU_NUM; u++) begin
                if (model_q[u].size() != 0) model_empty_o = 1'b0;
            end
        end
    end

endmodule

/* sim/issue_stage_tb.sv */
/*
 * Issue stage testbench: clock, reset, directed and random bundles,
 * FU reads, timeout and closing summary
 */

`timescale 1ns/1ps

`include "issue_consts.svh"

module issue_stage_tb import isa_pkg::*, issue_pkg::*; ();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 3;
    localparam int RANDOM_CYCLES  = 400;
    // About three times the length of all tests together
    localparam int TIMEOUT_CYCLES = 2000;

    logic                             clk;
    logic                             reset;
    logic          [`ISSUE_WIDTH-1:0] issue_valid;
    issue_packet_t [`ISSUE_WIDTH-1:0] issue_pkt;
    logic                             stall;
    logic          [`FU_NUM-1:0]      fu_rd_en;
    issue_packet_t [`FU_NUM-1:0]      fu_pkt;
    logic          [`FU_NUM-1:0]      fu_empty;

    int                               checker_errors;
    logic                             model_empty;
    int                               tb_errors;
    int                               errors_before;
    int                               tests_run;
    int                               tests_failed;
    int                               cycle_count;
    int                               seed;
    logic [`ROB_TAG_BITS-1:0]         next_tag;
    // Stall as seen just before the last edge
    logic                             stall_seen;

    issue_stage_top i_issue_stage_top (
        .clk           (clk),
        .reset         (reset),
        .issue_valid_i (issue_valid),
        .issue_pkt_i   (issue_pkt),
        .stall_o       (stall),
        .fu_rd_en_i    (fu_rd_en),
        .fu_pkt_o      (fu_pkt),
        .fu_empty_o    (fu_empty)
    );

    issue_stage_checker #(.SAMPLE_DELAY(CLK_PERIOD - 1)) i_issue_stage_checker (
        .clk           (clk),
        .reset         (reset),
        .issue_valid_i (issue_valid),
        .issue_pkt_i   (issue_pkt),
        .stall_i       (stall),
        .fu_rd_en_i    (fu_rd_en),
        .fu_pkt_i      (fu_pkt),
        .fu_empty_i    (fu_empty),
        .error_count_o (checker_errors),
        .model_empty_o (model_empty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ========================================
    // Stimulus helpers
    // ========================================
    task automatic make_pkt(input opcode_e op, output issue_packet_t p);
        p.opcode  = op;
        p.rob_tag = next_tag;
        p.src1    = {$random(seed), $random(seed)};
        p.src2    = {$random(seed), $random(seed)};
        next_tag  = next_tag + 1'b1;
    endtask

    // Sample stall before the edge, return 1 ns after it
    task automatic end_cycle();
        #(CLK_PERIOD - 2);
        stall_seen = stall;
        @(posedge clk);
        #1;
    endtask

    // Hold the bundle until taken, count the cycles
    task automatic send_bundle(input logic [`ISSUE_WIDTH-1:0] valid, input issue_packet_t p0,
                               input issue_packet_t p1, output int cycles);
        issue_valid  = valid;
        issue_pkt[0] = p0;
        issue_pkt[1] = p1;
        cycles       = 0;
        do begin
            end_cycle();
            cycles++;
        end while (stall_seen);
        issue_valid = '0;
    endtask

    task automatic drain_all();
        fu_rd_en = '1;
        do begin
            end_cycle();
        end while (fu_empty != '1);
        fu_rd_en = '0;
    endtask

    task automatic expect_true(input logic cond, input string msg);
        if (!cond) begin
            tb_errors++;
            $display("Error at %0t: %s", $time, msg);
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = tb_errors + checker_errors - errors_before;
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errs);
        end
        errors_before = tb_errors + checker_errors;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        issue_packet_t p0;
        issue_packet_t p1;
        int            cycles;
        seed          = 32'hadca_4df5;
        reset         = 1'b1;
        issue_valid   = '0;
        issue_pkt     = '0;
        fu_rd_en      = '0;
        next_tag      = '0;
        tb_errors     = 0;
        errors_before = 0;
        tests_run     = 0;
        tests_failed  = 0;
        stall_seen    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        end_cycle();
        expect_true(fu_empty == '1 && !stall_seen && fu_pkt == '0, "outputs not idle after reset");
        finish_test("reset state");

        // One packet per opcode, ADD first
        for (int i = 0; i < 10; i++) begin
            make_pkt(opcode_e'(4'(i)), p0);
            send_bundle(2'b01, p0, p0, cycles);
        end
        // Six ALU ops fill ALU0 and spill two into ALU1
        expect_true(fu_empty == 6'b000100, "queue occupancy wrong after routing");
        drain_all();
        finish_test("routing and order");

        make_pkt(ADD, p0);
        make_pkt(SUB, p1);
        send_bundle(2'b11, p0, p1, cycles);
        expect_true(cycles == 1 && fu_empty[2:0] == 3'b100, "ALU pair not spread over ALU0/1");
        make_pkt(MUL, p0);
        make_pkt(MUL, p1);
        send_bundle(2'b11, p0, p1, cycles);
        expect_true(cycles == 2, "MUL pair did not take exactly one stall cycle");
        drain_all();
        finish_test("ALU balancing and collisions");

        for (int i = 0; i < 4; i++) begin
            make_pkt(LD, p0);
            send_bundle(2'b01, p0, p0, cycles);
        end
        // Fifth LD blocks, XOR beside it goes through
        make_pkt(LD, p0);
        make_pkt(XOR, p1);
        issue_valid  = 2'b11;
        issue_pkt[0] = p0;
        issue_pkt[1] = p1;
        repeat (3) begin
            end_cycle();
            expect_true(stall_seen, "stall dropped while LOAD0 is full");
        end
        expect_true(!fu_empty[ALU0], "XOR in the held bundle was not accepted");
        // Space from a read counts only from the next cycle
        fu_rd_en[LOAD0] = 1'b1;
        end_cycle();
        expect_true(stall_seen, "stall dropped in the read cycle");
        fu_rd_en = '0;
        end_cycle();
        expect_true(!stall_seen, "held LD not accepted after the read");
        issue_valid = '0;
        drain_all();
        finish_test("full back-pressure");

        stall_seen = 1'b0;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            // New bundle only once the last one was taken
            if (!stall_seen) begin
                issue_valid = 2'($random(seed));
                make_pkt(opcode_e'(4'($unsigned($random(seed)) % 10)), issue_pkt[0]);
                make_pkt(opcode_e'(4'($unsigned($random(seed)) % 10)), issue_pkt[1]);
            end
            fu_rd_en = 6'($random(seed));
            end_cycle();
        end
        fu_rd_en = '1;
        while (stall_seen) end_cycle();
        issue_valid = '0;
        drain_all();
        // DUT queues are empty here, the model must agree
        expect_true(model_empty, "model queues not empty after the DUT drained");
        finish_test("random traffic");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 tb_errors + checker_errors);
        if (tests_failed == 0 && tb_errors + checker_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/isa_pkg.sv
source/issue_pkg.sv
source/fu_fifo.sv
source/fu_fifo_bank.sv
source/issue_dispatch.sv
source/issue_stage_top.sv
sim/issue_stage_checker.sv
sim/issue_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the issue stage testbench with Verilator, run it and scan the log

LOG=sim.log

verilator --binary --timing --top-module issue_stage_tb -f sources.f \
    -o issue_stage_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/issue_stage_sim > "$LOG" 2>&1 \
    || { cat "$LOG"; echo "Simulation exited with an error"; exit 1; }

cat "$LOG"

grep -q '>>> FAIL' "$LOG" && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"
